/* Makefile */
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing -Wno-fatal -j 0 --top-module tb_rob -Mdir obj_dir -f list.f
	./obj_dir/Vtb_rob | tee $(LOG)
	@grep -qF "*** TEST PASSED ***" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* design/reg_file.sv */
`default_nettype none

module reg_file (
    input  logic              clk,
    input  logic              rst,
    input  logic              rename_en,
    input  rob_pkg::reg_idx_t rename_rd,
    input  rob_pkg::rob_tag_t rename_tag,
    input  rob_pkg::commit_t  commit,
    input  logic              flush,
    input  rob_pkg::reg_idx_t src,
    output rob_pkg::operand_t operand,
    input  rob_pkg::reg_idx_t st_rd_idx,
    output rob_pkg::word_t    st_data
);
    import rob_pkg::*;

    word_t               value_q [num_regs];
    rob_tag_t            tag_q   [num_regs];
    logic [num_regs-1:0] busy_q;

    logic rename_hit;
    logic commit_hit;

    // x0 is hardwired, so it is never written or renamed
    assign rename_hit = rename_en && (rename_rd != '0);
    assign commit_hit = commit.valid && (commit.rd != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q <= '0;
            for (int i = 0; i < num_regs; i++) begin
                value_q[i] <= '0;
            end
        end else begin
            if (commit_hit) begin
                value_q[commit.rd] <= commit.value;
                // a younger producer keeps the register busy
                if (tag_q[commit.rd] == commit.tag) begin
                    busy_q[commit.rd] <= 1'b0;
                end
            end
            if (flush) begin
                busy_q <= '0;
            end
            // a rename in the same cycle overrides commit and flush
            if (rename_hit) begin
                busy_q[rename_rd] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rename_hit) begin
            tag_q[rename_rd] <= rename_tag;
        end
    end

    // bypass the commit that lands at the coming edge
    always_comb begin
        operand.busy  = busy_q[src] && !flush;
        operand.tag   = tag_q[src];
        operand.value = value_q[src];
        if (commit_hit && (commit.rd == src)) begin
            operand.value = commit.value;
            if (tag_q[src] == commit.tag) begin
                operand.busy = 1'b0;
            end
        end
    end

    assign st_data = (commit_hit && (commit.rd == st_rd_idx)) ? commit.value
                                                              : value_q[st_rd_idx];

endmodule

`default_nettype wire

/* design/rob.sv */
`default_nettype none

module rob (
    input  logic               clk,
    input  logic               rst,
    input  logic               dispatch_valid,
    input  rob_pkg::dispatch_t dispatch,
    input  logic               complete_valid,
    input  rob_pkg::complete_t complete,
    input  logic               mem_resp,
    input  rob_pkg::word_t     mem_rdata,
    input  rob_pkg::word_t     head_value,
    input  rob_pkg::word_t     st_data,
    output rob_pkg::rob_tag_t  alloc_tag,
    output logic               rob_full,
    output logic               rename_en,
    output rob_pkg::rob_tag_t  value_rd_tag,
    output rob_pkg::reg_idx_t  st_rd_idx,
    output logic               mem_read,
    output logic               mem_write,
    output rob_pkg::word_t     mem_addr,
    output rob_pkg::word_t     mem_wdata,
    output rob_pkg::commit_t   commit,
    output logic               flush
);
    import rob_pkg::*;

    rob_tag_t   head_q;
    rob_tag_t   tail_q;
    rob_count_t count_q;

    // per-entry fields, indexed by tag
    op_t      op_q     [rob_entries];
    reg_idx_t rd_q     [rob_entries];
    reg_idx_t st_src_q [rob_entries];
    logic [rob_entries-1:0] alloc_q;
    logic [rob_entries-1:0] done_q;
    logic [rob_entries-1:0] mispred_q;

    logic     dispatch_fire;
    logic     complete_hit;
    logic     head_ready;
    logic     retire;
    logic     mispredict_retire;
    op_t      head_op;

    logic     commit_valid_q;
    reg_idx_t commit_rd_q;
    rob_tag_t commit_tag_q;
    word_t    commit_value_q;
    logic     flush_q;

    assign rob_full      = (count_q == rob_count_t'(rob_entries));
    assign alloc_tag     = tail_q;
    assign dispatch_fire = dispatch_valid && !rob_full;
    // stores and branches leave no register to rename
    assign rename_en     = dispatch_fire && (dispatch.op == op_alu || dispatch.op == op_ld);
    // completions for free slots are dropped
    assign complete_hit  = complete_valid && alloc_q[complete.tag];

    assign head_op    = op_q[head_q];
    assign head_ready = alloc_q[head_q] && done_q[head_q];

    // memory requests stay up until the cache answers
    assign mem_read     = head_ready && (head_op == op_ld);
    assign mem_write    = head_ready && (head_op == op_st);
    assign value_rd_tag = head_q;
    assign st_rd_idx    = st_src_q[head_q];
    assign mem_addr     = head_value;
    assign mem_wdata    = st_data;

    assign retire = head_ready && (head_op == op_alu || head_op == op_br || mem_resp);
    assign mispredict_retire = retire && (head_op == op_br) && mispred_q[head_q];

    always_ff @(posedge clk) begin
        if (rst) begin
            head_q         <= '0;
            tail_q         <= '0;
            count_q        <= '0;
            alloc_q        <= '0;
            done_q         <= '0;
            commit_valid_q <= 1'b0;
            flush_q        <= 1'b0;
        end else begin
            commit_valid_q <= retire && (head_op == op_alu || head_op == op_ld);
            flush_q        <= mispredict_retire;

            if (complete_hit) begin
                done_q[complete.tag] <= 1'b1;
            end

            if (dispatch_fire) begin
                alloc_q[tail_q] <= 1'b1;
                done_q[tail_q]  <= 1'b0;
                tail_q          <= tail_q + 1'b1;
            end

            if (retire) begin
                alloc_q[head_q] <= 1'b0;
                head_q          <= head_q + 1'b1;
            end

            if (dispatch_fire && !retire) begin
                count_q <= count_q + 1'b1;
            end else if (retire && !dispatch_fire) begin
                count_q <= count_q - 1'b1;
            end

            // the branch was the oldest entry, so everything left is younger
            if (mispredict_retire) begin
                alloc_q <= '0;
                tail_q  <= head_q + 1'b1;
                count_q <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (dispatch_fire) begin
            op_q[tail_q]     <= dispatch.op;
            rd_q[tail_q]     <= dispatch.rd;
            st_src_q[tail_q] <= dispatch.st_src;
        end
        if (complete_hit) begin
            mispred_q[complete.tag] <= complete.mispredict;
        end
        if (retire) begin
            commit_rd_q    <= rd_q[head_q];
            commit_tag_q   <= head_q;
            // a load commits the word returned by the cache
            commit_value_q <= (head_op == op_ld) ? mem_rdata : head_value;
        end
    end

    always_comb begin
        commit.valid = commit_valid_q;
        commit.rd    = commit_rd_q;
        commit.tag   = commit_tag_q;
        commit.value = commit_value_q;
    end

    assign flush = flush_q;

endmodule

`default_nettype wire

/* design/rob_pkg.sv */
`default_nettype none

package rob_pkg;

    localparam int rob_entries = 8;
    localparam int num_regs = 32;

    typedef logic [$clog2(rob_entries)-1:0] rob_tag_t;
    typedef logic [$clog2(rob_entries):0]   rob_count_t;
    typedef logic [4:0]                     reg_idx_t;
    typedef logic [31:0]                    word_t;

    typedef enum logic [1:0] {
        op_alu,
        op_ld,
        op_st,
        op_br
    } op_t;

    // one instruction from the issue stage
    typedef struct packed {
        op_t      op;
        reg_idx_t rd;
        reg_idx_t st_src;
        reg_idx_t src;
    } dispatch_t;

    // value is the ALU result, or the address for loads and stores
    typedef struct packed {
        rob_tag_t tag;
        word_t    value;
        logic     mispredict;
    } complete_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        rob_tag_t tag;
        word_t    value;
    } commit_t;

    typedef struct packed {
        logic     busy;
        rob_tag_t tag;
        word_t    value;
    } operand_t;

endpackage

`default_nettype wire

/* design/rob_subsystem.sv */
`default_nettype none

module rob_subsystem (
    input  logic               clk,
    input  logic               rst,
    input  logic               dispatch_valid,
    input  rob_pkg::dispatch_t dispatch,
    input  logic               complete_valid,
    input  rob_pkg::complete_t complete,
    input  logic               mem_resp,
    input  rob_pkg::word_t     mem_rdata,
    output rob_pkg::rob_tag_t  alloc_tag,
    output logic               rob_full,
    output rob_pkg::operand_t  operand,
    output logic               mem_read,
    output logic               mem_write,
    output rob_pkg::word_t     mem_addr,
    output rob_pkg::word_t     mem_wdata,
    output rob_pkg::commit_t   commit,
    output logic               flush
);
    import rob_pkg::*;

    logic     rename_en;
    rob_tag_t value_rd_tag;
    word_t    head_value;
    reg_idx_t st_rd_idx;
    word_t    st_data;

    rob u_rob (
        .clk            (clk),
        .rst            (rst),
        .dispatch_valid (dispatch_valid),
        .dispatch       (dispatch),
        .complete_valid (complete_valid),
        .complete       (complete),
        .mem_resp       (mem_resp),
        .mem_rdata      (mem_rdata),
        .head_value     (head_value),
        .st_data        (st_data),
        .alloc_tag      (alloc_tag),
        .rob_full       (rob_full),
        .rename_en      (rename_en),
        .value_rd_tag   (value_rd_tag),
        .st_rd_idx      (st_rd_idx),
        .mem_read       (mem_read),
        .mem_write      (mem_write),
        .mem_addr       (mem_addr),
        .mem_wdata      (mem_wdata),
        .commit         (commit),
        .flush          (flush)
    );

    // payloads are captured straight off the completion bus
    rob_value_buf u_value_buf (
        .clk            (clk),
        .rst            (rst),
        .complete_valid (complete_valid),
        .complete       (complete),
        .value_rd_tag   (value_rd_tag),
        .head_value     (head_value)
    );

    reg_file u_reg_file (
        .clk        (clk),
        .rst        (rst),
        .rename_en  (rename_en),
        .rename_rd  (dispatch.rd),
        .rename_tag (alloc_tag),
        .commit     (commit),
        .flush      (flush),
        .src        (dispatch.src),
        .operand    (operand),
        .st_rd_idx  (st_rd_idx),
        .st_data    (st_data)
    );

endmodule

`default_nettype wire

/* design/rob_value_buf.sv */
`default_nettype none

module rob_value_buf (
    input  logic               clk,
    input  logic               rst,
    input  logic               complete_valid,
    input  rob_pkg::complete_t complete,
    input  rob_pkg::rob_tag_t  value_rd_tag,
    output rob_pkg::word_t     head_value
);
    import rob_pkg::*;

    // result of ALU ops, effective address of loads and stores
    word_t value_q [rob_entries];

    always_ff @(posedge clk) begin
        // nothing is captured while the core is held in reset
        if (complete_valid && !rst) begin
            value_q[complete.tag] <= complete.value;
        end
    end

    assign head_value = value_q[value_rd_tag];

endmodule

`default_nettype wire

/* list.f */
design/rob_pkg.sv
design/rob.sv
design/rob_value_buf.sv
design/reg_file.sv
design/rob_subsystem.sv
sim/rob_checker.sv
sim/tb_rob.sv

/* sim/rob_checker.sv */
`default_nettype none

module rob_checker (
    input  logic               clk,
    input  logic               rst,
    input  logic               run_done,
    input  logic               dispatch_valid,
    input  rob_pkg::dispatch_t dispatch,
    input  logic               complete_valid,
    input  rob_pkg::complete_t complete,
    input  logic               mem_resp,
    input  rob_pkg::rob_tag_t  alloc_tag,
    input  logic               rob_full,
    input  rob_pkg::operand_t  operand,
    input  logic               mem_read,
    input  logic               mem_write,
    input  rob_pkg::word_t     mem_addr,
    input  rob_pkg::word_t     mem_wdata,
    input  rob_pkg::commit_t   commit,
    input  logic               flush,
    output logic               model_empty,
    output logic               report_ready,
    output int                 error_count
);
    import rob_pkg::*;

    typedef struct packed {
        rob_tag_t tag;
        op_t      op;
        reg_idx_t rd;
        reg_idx_t st_src;
        logic     done;
        logic     mispredict;
        word_t    value;
    } entry_t;

    // unretired entries, oldest first
    entry_t   rob_q[$];
    word_t    reg_val [num_regs];
    word_t    mem_val [16];
    rob_tag_t tail;
    commit_t  exp_commit;
    logic     exp_flush;
    int       checks [1:6];
    int       errors [1:6];

    function automatic word_t mem_fill(input int idx);
        word_t addr;
        addr = word_t'(idx * 4);
        return 32'h3c00_0000 ^ (addr * 32'h0001_0003);
    endfunction

    function automatic string test_name(input int t);
        case (t)
            1: return "in-order commit";
            2: return "full flag";
            3: return "loads";
            4: return "stores";
            5: return "mispredict flush";
            default: return "renaming";
        endcase
    endfunction

    task automatic check(input int test, input string name, input word_t got, input word_t exp);
        checks[test]++;
        if (got !== exp) begin
            errors[test]++;
            error_count++;
            $display("Error: %s expected 0x%08h, got 0x%08h at time %0t", name, exp, got, $time);
        end
    endtask

    task automatic reset_model();
        rob_q.delete();
        for (int i = 0; i < num_regs; i++) begin
            reg_val[i] = '0;
        end
        for (int i = 0; i < 16; i++) begin
            mem_val[i] = mem_fill(i);
        end
        tail       = '0;
        exp_commit = '0;
        exp_flush  = 1'b0;
    endtask

    task automatic check_outputs();
        entry_t head;
        logic   head_ready;
        int     youngest;
        head_ready = (rob_q.size() > 0) && rob_q[0].done;
        head       = head_ready ? rob_q[0] : '0;

        check(1, "commit.valid", word_t'(commit.valid), word_t'(exp_commit.valid));
        if (exp_commit.valid && commit.valid) begin
            check(1, "commit.rd", word_t'(commit.rd), word_t'(exp_commit.rd));
            check(1, "commit.tag", word_t'(commit.tag), word_t'(exp_commit.tag));
            check(1, "commit.value", commit.value, exp_commit.value);
        end

        check(2, "rob_full", word_t'(rob_full), word_t'(rob_q.size() == rob_entries));
        check(2, "alloc_tag", word_t'(alloc_tag), word_t'(tail));

        check(3, "mem_read", word_t'(mem_read), word_t'(head_ready && head.op == op_ld));
        check(4, "mem_write", word_t'(mem_write), word_t'(head_ready && head.op == op_st));
        if (head_ready && (head.op == op_ld || head.op == op_st)) begin
            check(head.op == op_ld ? 3 : 4, "mem_addr", mem_addr, head.value);
        end
        if (head_ready && head.op == op_st) begin
            check(4, "mem_wdata", mem_wdata, reg_val[head.st_src]);
        end

        check(5, "flush", word_t'(flush), word_t'(exp_flush));

        if (dispatch_valid) begin
            youngest = -1;
            for (int i = 0; i < rob_q.size(); i++) begin
                if ((rob_q[i].op == op_alu || rob_q[i].op == op_ld) &&
                    rob_q[i].rd == dispatch.src && dispatch.src != '0) begin
                    youngest = i;
                end
            end
            check(6, "operand.busy", word_t'(operand.busy), word_t'(youngest >= 0));
            if (youngest >= 0) begin
                check(6, "operand.tag", word_t'(operand.tag), word_t'(rob_q[youngest].tag));
            end else begin
                check(6, "operand.value", operand.value, reg_val[dispatch.src]);
            end
        end
    endtask

    task automatic update_model();
        entry_t head;
        entry_t tmp;
        logic   retire;
        word_t  value;
        retire     = 1'b0;
        head       = '0;
        exp_commit = '0;
        exp_flush  = 1'b0;
        // a completion seen now only counts from the next cycle
        if (rob_q.size() > 0 && rob_q[0].done) begin
            head   = rob_q[0];
            retire = (head.op == op_alu || head.op == op_br || mem_resp);
        end
        if (complete_valid) begin
            for (int i = 0; i < rob_q.size(); i++) begin
                if (rob_q[i].tag == complete.tag) begin
                    tmp            = rob_q[i];
                    tmp.done       = 1'b1;
                    tmp.value      = complete.value;
                    tmp.mispredict = complete.mispredict;
                    rob_q[i]       = tmp;
                end
            end
        end
        if (dispatch_valid && rob_q.size() < rob_entries) begin
            tmp        = '0;
            tmp.tag    = tail;
            tmp.op     = dispatch.op;
            tmp.rd     = dispatch.rd;
            tmp.st_src = dispatch.st_src;
            rob_q.push_back(tmp);
            tail = tail + 1'b1;
        end
        if (retire) begin
            void'(rob_q.pop_front());
            value = (head.op == op_ld) ? mem_val[head.value[5:2]] : head.value;
            if (head.op == op_alu || head.op == op_ld) begin
                exp_commit.valid = 1'b1;
                exp_commit.rd    = head.rd;
                exp_commit.tag   = head.tag;
                exp_commit.value = value;
                if (head.rd != '0) begin
                    reg_val[head.rd] = value;
                end
            end else if (head.op == op_st) begin
                mem_val[head.value[5:2]] = reg_val[head.st_src];
            end else if (head.mispredict) begin
                // the branch was oldest, so the whole buffer goes
                rob_q.delete();
                tail      = head.tag + 1'b1;
                exp_flush = 1'b1;
            end
        end
    endtask

    initial begin
        for (int t = 1; t <= 6; t++) begin
            checks[t] = 0;
            errors[t] = 0;
        end
        error_count  = 0;
        report_ready = 1'b0;
        model_empty  = 1'b1;
        reset_model();
    end

    always @(negedge clk) begin
        if (rst) begin
            reset_model();
        end else if (run_done) begin
            if (!report_ready) begin
                for (int t = 1; t <= 6; t++) begin
                    $display("test %0d %s: %0d checks, %0d errors",
                             t, test_name(t), checks[t], errors[t]);
                end
                $display("all tests done, %0d errors", error_count);
                report_ready = 1'b1;
            end
        end else begin
            check_outputs();
            update_model();
        end
        model_empty = (rob_q.size() == 0) && !exp_commit.valid && !exp_flush;
    end

endmodule

`default_nettype wire

/* sim/tb_rob.sv */
`default_nettype none

module tb_rob;
    import rob_pkg::*;

    logic      clk;
    logic      rst;
    logic      dispatch_valid;
    dispatch_t dispatch;
    logic      complete_valid;
    complete_t complete;
    logic      mem_resp;
    word_t     mem_rdata;
    rob_tag_t  alloc_tag;
    logic      rob_full;
    operand_t  operand;
    logic      mem_read;
    logic      mem_write;
    word_t     mem_addr;
    word_t     mem_wdata;
    commit_t   commit;
    logic      flush;

    logic run_done;
    logic model_empty;
    logic report_ready;
    int   error_count;

    // data cache contents and the tags still waiting for a result
    word_t    mem_data [16];
    rob_tag_t pend_tag[$];
    op_t      pend_op[$];
    logic     mem_busy;
    int       mem_wait;

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    rob_subsystem u_dut (
        .clk            (clk),
        .rst            (rst),
        .dispatch_valid (dispatch_valid),
        .dispatch       (dispatch),
        .complete_valid (complete_valid),
        .complete       (complete),
        .mem_resp       (mem_resp),
        .mem_rdata      (mem_rdata),
        .alloc_tag      (alloc_tag),
        .rob_full       (rob_full),
        .operand        (operand),
        .mem_read       (mem_read),
        .mem_write      (mem_write),
        .mem_addr       (mem_addr),
        .mem_wdata      (mem_wdata),
        .commit         (commit),
        .flush          (flush)
    );

    rob_checker u_chk (
        .clk            (clk),
        .rst            (rst),
        .run_done       (run_done),
        .dispatch_valid (dispatch_valid),
        .dispatch       (dispatch),
        .complete_valid (complete_valid),
        .complete       (complete),
        .mem_resp       (mem_resp),
        .alloc_tag      (alloc_tag),
        .rob_full       (rob_full),
        .operand        (operand),
        .mem_read       (mem_read),
        .mem_write      (mem_write),
        .mem_addr       (mem_addr),
        .mem_wdata      (mem_wdata),
        .commit         (commit),
        .flush          (flush),
        .model_empty    (model_empty),
        .report_ready   (report_ready),
        .error_count    (error_count)
    );

    // answers 1 to 4 cycles after the request first shows up
    task automatic serve_memory();
        if (mem_read || mem_write) begin
            if (!mem_busy) begin
                mem_busy = 1'b1;
                mem_wait = $urandom_range(0, 3);
            end
            if (mem_wait == 0) begin
                mem_resp  = 1'b1;
                mem_rdata = mem_data[mem_addr[5:2]];
                if (mem_write) begin
                    mem_data[mem_addr[5:2]] = mem_wdata;
                end
                mem_busy = 1'b0;
            end else begin
                mem_wait--;
            end
        end
    endtask

    task automatic drive_cycle(input logic allow_dispatch);
        int pick;
        @(posedge clk);
        #2;
        dispatch_valid = 1'b0;
        complete_valid = 1'b0;
        mem_resp       = 1'b0;
        if (flush) begin
            pend_tag.delete();
            pend_op.delete();
        end
        // complete one waiting entry, picked at random
        if (pend_tag.size() > 0 && $urandom_range(0, 3) != 0) begin
            pick                = $urandom_range(0, pend_tag.size() - 1);
            complete.tag        = pend_tag[pick];
            complete.mispredict = (pend_op[pick] == op_br) && ($urandom_range(0, 5) == 0);
            if (pend_op[pick] == op_ld || pend_op[pick] == op_st) begin
                complete.value = {26'b0, 4'($urandom_range(0, 15)), 2'b0};
            end else begin
                complete.value = $urandom();
            end
            complete_valid = 1'b1;
            pend_tag.delete(pick);
            pend_op.delete(pick);
        end
        if (allow_dispatch && !rob_full && $urandom_range(0, 2) != 0) begin
            dispatch.op     = op_t'($urandom_range(0, 3));
            dispatch.rd     = 5'($urandom_range(0, 7));
            dispatch.st_src = 5'($urandom_range(0, 7));
            dispatch.src    = 5'($urandom_range(0, 7));
            dispatch_valid  = 1'b1;
            pend_tag.push_back(alloc_tag);
            pend_op.push_back(dispatch.op);
        end
        serve_memory();
    endtask

    initial begin
        int   cyc;
        logic timed_out;
        void'($urandom(32'h7861bbf1));
        rst            = 1'b1;
        dispatch_valid = 1'b0;
        dispatch       = '0;
        complete_valid = 1'b0;
        complete       = '0;
        mem_resp       = 1'b0;
        mem_rdata      = '0;
        run_done       = 1'b0;
        mem_busy       = 1'b0;
        mem_wait       = 0;
        timed_out      = 1'b0;
        for (int i = 0; i < 16; i++) begin
            mem_data[i] = 32'h3c00_0000 ^ (word_t'(i * 4) * 32'h0001_0003);
        end
        repeat (10) @(posedge clk);
        #2;
        rst = 1'b0;

        repeat (3000) drive_cycle(1'b1);

        // let the buffer drain with no new dispatches
        cyc = 0;
        while (!model_empty && cyc < 500) begin
            drive_cycle(1'b0);
            cyc++;
        end
        if (!model_empty) begin
            timed_out = 1'b1;
            $display("timeout: the reorder buffer did not drain");
        end else begin
            run_done = 1'b1;
            cyc      = 0;
            while (!report_ready && cyc < 20) begin
                @(posedge clk);
                cyc++;
            end
            if (!report_ready) begin
                timed_out = 1'b1;
                $display("timeout: the checker gave no report");
            end
        end

        if (timed_out || error_count != 0) begin
            $display("*** TEST FAILED ***");
        end else begin
            $display("*** TEST PASSED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire
